// ==== hdl/hl_video_pkg.sv ====
package hl_video_pkg;

    typedef logic [23:0] pixel_t;         // 8 bits each of R, G, B.
    typedef logic signed [15:0] coord_t;  // Signed so off-frame points stay visible.

    localparam pixel_t HIGHLIGHT_COLOR = 24'h00FF00;  // Pure green.

endpackage

// ==== hdl/hl_ctrl_pkg.sv ====
package hl_ctrl_pkg;

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_ANGLE  = 8'h00;
    localparam apb_addr_t REG_RADIUS = 8'h04;
    localparam apb_addr_t REG_CTRL   = 8'h08;
    localparam apb_addr_t REG_STATUS = 8'h0C;

    // Angle index k stands for 15*k degrees.
    typedef logic [3:0] angle_idx_t;
    localparam angle_idx_t ANGLE_MAX = 4'd11;  // 165 degrees.

    typedef logic signed [15:0] radius_t;

    // Sine and cosine scaled by 2**FRAC_BITS.
    typedef logic signed [15:0] trig_t;
    localparam int FRAC_BITS = 13;

endpackage

// ==== hdl/frame_mem_if.sv ====
`timescale 1ns/1ps

interface frame_mem_if #(
    parameter int ADDR_WIDTH = 12
);
    logic req;
    logic grant;
    logic we;
    logic [ADDR_WIDTH-1:0] addr;
    hl_video_pkg::pixel_t wdata;
    hl_video_pkg::pixel_t rdata;  // Valid one cycle after the granted edge.

    modport client (
        output req, we, addr, wdata,
        input  grant, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output grant, rdata
    );
endinterface

// ==== hdl/hl_apb_regs.sv ====
`timescale 1ns/1ps

module hl_apb_regs (
    input  logic clock,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  hl_ctrl_pkg::apb_addr_t paddr,
    input  hl_ctrl_pkg::apb_data_t pwdata,
    output hl_ctrl_pkg::apb_data_t prdata,
    output logic pready,
    input  logic load_done,
    input  logic draw_done,
    input  logic read_done,
    output logic draw_start,
    output logic loader_arm,
    output hl_ctrl_pkg::angle_idx_t angle,
    output hl_ctrl_pkg::radius_t radius
);
    typedef enum logic [1:0] {PH_IDLE, PH_LOADED, PH_DRAWING, PH_READING} phase_t;

    phase_t phase;
    logic read_out;
    logic loaded;
    logic drawn;
    logic wr_en;
    logic start_ok;

    assign pready = 1'b1;  // No wait states.
    assign wr_en = psel && penable && pwrite;
    assign loaded = (phase != PH_IDLE);
    assign drawn = (phase == PH_READING);
    assign start_ok = wr_en && (paddr == hl_ctrl_pkg::REG_CTRL) && pwdata[0]
                      && (phase == PH_LOADED);

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                hl_ctrl_pkg::REG_ANGLE:  prdata = {28'b0, angle};
                hl_ctrl_pkg::REG_RADIUS: prdata = {16'b0, radius};
                hl_ctrl_pkg::REG_STATUS: prdata = {29'b0, read_out, drawn, loaded};
                default:                 prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= PH_IDLE;
            read_out <= 1'b0;
            draw_start <= 1'b0;
            loader_arm <= 1'b0;
            angle <= '0;
            radius <= '0;
        end else begin
            draw_start <= 1'b0;
            loader_arm <= 1'b0;
            if (wr_en && (paddr == hl_ctrl_pkg::REG_ANGLE)) begin
                // Out-of-range indices saturate at 165 degrees.
                if (pwdata > 32'(hl_ctrl_pkg::ANGLE_MAX))
                    angle <= hl_ctrl_pkg::ANGLE_MAX;
                else
                    angle <= pwdata[3:0];
            end
            if (wr_en && (paddr == hl_ctrl_pkg::REG_RADIUS))
                radius <= pwdata[15:0];
            case (phase)
                PH_IDLE: begin
                    if (load_done) begin
                        phase <= PH_LOADED;
                        read_out <= 1'b0;
                    end
                end
                PH_LOADED: begin
                    if (start_ok) begin
                        draw_start <= 1'b1;
                        phase <= PH_DRAWING;
                    end
                end
                PH_DRAWING: begin
                    if (draw_done)
                        phase <= PH_READING;  // Reader starts on the same pulse.
                end
                default: begin
                    if (read_done) begin
                        phase <= PH_IDLE;
                        read_out <= 1'b1;
                        loader_arm <= 1'b1;
                    end
                end
            endcase
        end
    end
endmodule

// ==== hdl/frame_loader.sv ====
`timescale 1ns/1ps

module frame_loader #(
    parameter int WIDTH = 64,
    parameter int HEIGHT = 48,
    parameter int ADDR_WIDTH = 12
) (
    input  logic clock,
    input  logic reset,
    input  logic loader_arm,
    input  logic in_empty,
    input  hl_video_pkg::pixel_t in_dout,
    output logic in_rd_en,
    output logic load_done,
    frame_mem_if.client mem
);
    typedef enum logic [1:0] {ARMED, LOADING, DONE} load_state_t;

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(WIDTH * HEIGHT - 1);

    load_state_t state;
    logic [ADDR_WIDTH-1:0] addr_q;

    // FIFO is first-word-fall-through, so in_dout is already the head.
    assign mem.req = (state == LOADING) && !in_empty;
    assign mem.we = 1'b1;
    assign mem.addr = addr_q;
    assign mem.wdata = in_dout;
    assign in_rd_en = mem.req && mem.grant;  // Pop exactly when the write lands.

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ARMED;
            addr_q <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                ARMED: begin
                    if (!in_empty)
                        state <= LOADING;
                end
                LOADING: begin
                    if (in_rd_en) begin
                        if (addr_q == LAST_ADDR) begin
                            state <= DONE;
                            load_done <= 1'b1;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (loader_arm) begin
                        state <= ARMED;
                        addr_q <= '0;
                    end
                end
            endcase
        end
    end
endmodule

// ==== hdl/line_drawer.sv ====
`timescale 1ns/1ps

module line_drawer #(
    parameter int WIDTH = 64,
    parameter int HEIGHT = 48,
    parameter int LINE_LENGTH = 64,
    parameter int ADDR_WIDTH = 12
) (
    input  logic clock,
    input  logic reset,
    input  logic draw_start,
    input  hl_ctrl_pkg::angle_idx_t angle,
    input  hl_ctrl_pkg::radius_t radius,
    output logic draw_done,
    frame_mem_if.client mem
);
    typedef enum logic [1:0] {IDLE, SETUP, STEP, DONE} draw_state_t;

    localparam int T_W = $clog2(LINE_LENGTH + 1);
    localparam logic [T_W-1:0] LAST_T = T_W'(LINE_LENGTH - 1);

    draw_state_t state;
    logic [T_W-1:0] t;
    hl_ctrl_pkg::trig_t sin_q;
    hl_ctrl_pkg::trig_t cos_q;
    hl_ctrl_pkg::radius_t radius_q;
    hl_video_pkg::coord_t x0;
    hl_video_pkg::coord_t y0;
    hl_video_pkg::coord_t x_pt;
    hl_video_pkg::coord_t y_pt;
    logic signed [31:0] x_prod;
    logic signed [31:0] y_prod;
    logic signed [31:0] dx_acc;  // t * -sin, kept at full precision.
    logic signed [31:0] dy_acc;  // t * cos.
    logic in_bounds;
    logic advance;

    // First quadrant of sine in 15 degree steps.
    function automatic hl_ctrl_pkg::trig_t quarter_sin(input int idx);
        case (idx)
            0:       quarter_sin = 16'sd0;
            1:       quarter_sin = 16'sd2120;
            2:       quarter_sin = 16'sd4096;
            3:       quarter_sin = 16'sd5793;
            4:       quarter_sin = 16'sd7094;
            5:       quarter_sin = 16'sd7913;
            default: quarter_sin = 16'sd8192;
        endcase
    endfunction

    function automatic hl_ctrl_pkg::trig_t sin_of(input int k);
        sin_of = (k <= 6) ? quarter_sin(k) : quarter_sin(12 - k);
    endfunction

    function automatic hl_ctrl_pkg::trig_t cos_of(input int k);
        cos_of = (k <= 6) ? quarter_sin(6 - k) : -quarter_sin(k - 6);
    endfunction

    assign x_prod = cos_q * radius_q;
    assign y_prod = sin_q * radius_q;
    assign x_pt = x0 + hl_video_pkg::coord_t'(dx_acc >>> hl_ctrl_pkg::FRAC_BITS);
    assign y_pt = y0 + hl_video_pkg::coord_t'(dy_acc >>> hl_ctrl_pkg::FRAC_BITS);
    assign in_bounds = (x_pt >= 0) && (x_pt < WIDTH) && (y_pt >= 0) && (y_pt < HEIGHT);

    assign mem.req = (state == STEP) && in_bounds;
    assign mem.we = 1'b1;
    assign mem.addr = ADDR_WIDTH'(y_pt * WIDTH + x_pt);
    assign mem.wdata = hl_video_pkg::HIGHLIGHT_COLOR;
    assign advance = (state == STEP) && (!in_bounds || mem.grant);  // Clipped steps skip.
    assign draw_done = (state == DONE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            t <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (draw_start)
                        state <= SETUP;
                end
                SETUP: begin
                    t <= '0;
                    state <= STEP;
                end
                STEP: begin
                    if (advance) begin
                        if (t == LAST_T)
                            state <= DONE;
                        else
                            t <= t + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && draw_start) begin
            sin_q <= sin_of(int'(angle));
            cos_q <= cos_of(int'(angle));
            radius_q <= radius;
        end
        if (state == SETUP) begin
            x0 <= hl_video_pkg::coord_t'(x_prod >>> hl_ctrl_pkg::FRAC_BITS);
            y0 <= hl_video_pkg::coord_t'(y_prod >>> hl_ctrl_pkg::FRAC_BITS);
            dx_acc <= '0;
            dy_acc <= '0;
        end else if (advance) begin
            dx_acc <= dx_acc - 32'(sin_q);
            dy_acc <= dy_acc + 32'(cos_q);
        end
    end
endmodule

// ==== hdl/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader #(
    parameter int WIDTH = 64,
    parameter int HEIGHT = 48,
    parameter int ADDR_WIDTH = 12
) (
    input  logic clock,
    input  logic reset,
    input  logic draw_done,
    input  logic out_full,
    output logic out_wr_en,
    output hl_video_pkg::pixel_t out_din,
    output logic read_done,
    frame_mem_if.client mem
);
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(WIDTH * HEIGHT - 1);

    logic running;
    logic all_issued;
    logic [ADDR_WIDTH-1:0] issue_addr;
    logic [ADDR_WIDTH-1:0] out_cnt;
    logic pending;  // Read granted last cycle, data on rdata now.
    logic [1:0] count;
    logic wptr;
    logic rptr;
    logic granted;
    hl_video_pkg::pixel_t buffer [2];

    // Buffer plus in-flight reads never exceed two entries.
    assign mem.req = running && !all_issued && ((count + 2'(pending)) < 2'd2);
    assign mem.we = 1'b0;
    assign mem.addr = issue_addr;
    assign mem.wdata = '0;
    assign granted = mem.req && mem.grant;

    assign out_wr_en = (count != 2'd0) && !out_full;
    assign out_din = buffer[rptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            all_issued <= 1'b0;
            issue_addr <= '0;
            out_cnt <= '0;
            pending <= 1'b0;
            count <= '0;
            wptr <= 1'b0;
            rptr <= 1'b0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            pending <= granted;
            count <= count + 2'(pending) - 2'(out_wr_en);
            if (pending)
                wptr <= ~wptr;
            if (out_wr_en)
                rptr <= ~rptr;
            if (granted) begin
                if (issue_addr == LAST_ADDR)
                    all_issued <= 1'b1;
                else
                    issue_addr <= issue_addr + 1'b1;
            end
            if (out_wr_en) begin
                if (out_cnt == LAST_ADDR) begin
                    running <= 1'b0;
                    read_done <= 1'b1;
                end else begin
                    out_cnt <= out_cnt + 1'b1;
                end
            end
            if (draw_done) begin
                running <= 1'b1;
                all_issued <= 1'b0;
                issue_addr <= '0;
                out_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pending)
            buffer[wptr] <= mem.rdata;
    end
endmodule

// ==== hdl/frame_store.sv ====
`timescale 1ns/1ps

module frame_store #(
    parameter int WIDTH = 64,
    parameter int HEIGHT = 48,
    parameter int ADDR_WIDTH = 12
) (
    input  logic clock,
    input  logic reset,
    frame_mem_if.arbiter load_port,
    frame_mem_if.arbiter draw_port,
    frame_mem_if.arbiter read_port
);
    logic [2:0] req;
    logic [2:0] grant;
    logic [2:0] rd_tag;  // Port whose read returns this cycle.
    logic [1:0] prio;    // Port with top priority.
    logic [1:0] gnt_idx;
    logic gnt_valid;
    logic sel_we;
    logic [ADDR_WIDTH-1:0] sel_addr;
    hl_video_pkg::pixel_t sel_wdata;
    hl_video_pkg::pixel_t ram_q;
    hl_video_pkg::pixel_t ram [WIDTH * HEIGHT];

    assign req = {read_port.req, draw_port.req, load_port.req};

    always_comb begin
        gnt_idx = '0;
        gnt_valid = 1'b0;
        // Walk from lowest to highest priority so the last hit wins.
        for (int i = 2; i >= 0; i--) begin
            if (req[(int'(prio) + i) % 3]) begin
                gnt_idx = 2'((int'(prio) + i) % 3);
                gnt_valid = 1'b1;
            end
        end
        grant = gnt_valid ? (3'b001 << gnt_idx) : 3'b000;
    end

    always_comb begin
        case (gnt_idx)
            2'd1: begin
                sel_we = draw_port.we;
                sel_addr = draw_port.addr;
                sel_wdata = draw_port.wdata;
            end
            2'd2: begin
                sel_we = read_port.we;
                sel_addr = read_port.addr;
                sel_wdata = read_port.wdata;
            end
            default: begin
                sel_we = load_port.we;
                sel_addr = load_port.addr;
                sel_wdata = load_port.wdata;
            end
        endcase
    end

    assign load_port.grant = grant[0];
    assign draw_port.grant = grant[1];
    assign read_port.grant = grant[2];
    assign load_port.rdata = rd_tag[0] ? ram_q : '0;
    assign draw_port.rdata = rd_tag[1] ? ram_q : '0;
    assign read_port.rdata = rd_tag[2] ? ram_q : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prio <= '0;
            rd_tag <= '0;
        end else begin
            rd_tag <= (gnt_valid && !sel_we) ? grant : 3'b000;
            if (gnt_valid)
                prio <= (gnt_idx == 2'd2) ? 2'd0 : gnt_idx + 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (gnt_valid && sel_we)
            ram[sel_addr] <= sel_wdata;
        ram_q <= ram[sel_addr];
    end
endmodule

// ==== hdl/highlight_top.sv ====
`timescale 1ns/1ps

module highlight_top #(
    parameter int WIDTH = 64,
    parameter int HEIGHT = 48,
    parameter int LINE_LENGTH = 64
) (
    input  logic clock,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  hl_ctrl_pkg::apb_addr_t paddr,
    input  hl_ctrl_pkg::apb_data_t pwdata,
    output hl_ctrl_pkg::apb_data_t prdata,
    output logic pready,
    input  logic in_empty,
    input  hl_video_pkg::pixel_t in_dout,
    output logic in_rd_en,
    input  logic out_full,
    output logic out_wr_en,
    output hl_video_pkg::pixel_t out_din
);
    localparam int ADDR_WIDTH = $clog2(WIDTH * HEIGHT);

    logic load_done;
    logic draw_start;
    logic draw_done;
    logic read_done;
    logic loader_arm;
    hl_ctrl_pkg::angle_idx_t angle;
    hl_ctrl_pkg::radius_t radius;

    frame_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) load_port ();
    frame_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) draw_port ();
    frame_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) read_port ();

    hl_apb_regs u_regs (
        .clock      (clock),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .load_done  (load_done),
        .draw_done  (draw_done),
        .read_done  (read_done),
        .draw_start (draw_start),
        .loader_arm (loader_arm),
        .angle      (angle),
        .radius     (radius)
    );

    frame_loader #(.WIDTH(WIDTH), .HEIGHT(HEIGHT), .ADDR_WIDTH(ADDR_WIDTH)) u_loader (
        .clock      (clock),
        .reset      (reset),
        .loader_arm (loader_arm),
        .in_empty   (in_empty),
        .in_dout    (in_dout),
        .in_rd_en   (in_rd_en),
        .load_done  (load_done),
        .mem        (load_port.client)
    );

    line_drawer #(
        .WIDTH       (WIDTH),
        .HEIGHT      (HEIGHT),
        .LINE_LENGTH (LINE_LENGTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) u_drawer (
        .clock      (clock),
        .reset      (reset),
        .draw_start (draw_start),
        .angle      (angle),
        .radius     (radius),
        .draw_done  (draw_done),
        .mem        (draw_port.client)
    );

    frame_reader #(.WIDTH(WIDTH), .HEIGHT(HEIGHT), .ADDR_WIDTH(ADDR_WIDTH)) u_reader (
        .clock     (clock),
        .reset     (reset),
        .draw_done (draw_done),
        .out_full  (out_full),
        .out_wr_en (out_wr_en),
        .out_din   (out_din),
        .read_done (read_done),
        .mem       (read_port.client)
    );

    frame_store #(.WIDTH(WIDTH), .HEIGHT(HEIGHT), .ADDR_WIDTH(ADDR_WIDTH)) u_store (
        .clock     (clock),
        .reset     (reset),
        .load_port (load_port.arbiter),
        .draw_port (draw_port.arbiter),
        .read_port (read_port.arbiter)
    );
endmodule

// ==== verification/highlight_tb.sv ====
`timescale 1ns/1ps

module highlight_tb;
    localparam int WIDTH = 16;
    localparam int HEIGHT = 12;
    localparam int LINE_LENGTH = 20;
    localparam int NPIX = WIDTH * HEIGHT;
    localparam int POLL_LIMIT = 2000;     // APB status reads.
    localparam int FRAME_TIMEOUT = 6000;  // Clock cycles.

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    hl_ctrl_pkg::apb_addr_t paddr;
    hl_ctrl_pkg::apb_data_t pwdata;
    hl_ctrl_pkg::apb_data_t prdata;
    logic pready;
    logic in_empty;
    hl_video_pkg::pixel_t in_dout;
    logic in_rd_en;
    logic out_full;
    logic out_wr_en;
    hl_video_pkg::pixel_t out_din;

    integer seed = 58234;
    int errors;
    int checks;
    logic full_random;
    logic pop_seen;
    hl_video_pkg::pixel_t in_q [$];
    hl_video_pkg::pixel_t out_q [$];
    hl_video_pkg::pixel_t frame_in [NPIX];
    hl_video_pkg::pixel_t golden [NPIX];

    highlight_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT), .LINE_LENGTH(LINE_LENGTH)) dut (
        .clock     (clock),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .in_empty  (in_empty),
        .in_dout   (in_dout),
        .in_rd_en  (in_rd_en),
        .out_full  (out_full),
        .out_wr_en (out_wr_en),
        .out_din   (out_din)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // Input FIFO model and output sink, both updated on the falling edge.
    initial begin
        in_empty = 1'b1;
        in_dout = '0;
        out_full = 1'b0;
        pop_seen = 1'b0;
        forever begin
            @(negedge clock);
            if (pop_seen && in_q.size() > 0)
                void'(in_q.pop_front());
            in_empty = (in_q.size() == 0);
            in_dout = (in_q.size() == 0) ? '0 : in_q[0];
            out_full = full_random && (($random(seed) & 1) == 1);
            #1;
            pop_seen = in_rd_en;  // Pop lands at the next rising edge.
            if (out_wr_en)
                out_q.push_back(out_din);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_write(input hl_ctrl_pkg::apb_addr_t addr,
                             input hl_ctrl_pkg::apb_data_t data);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clock);
        penable = 1'b1;
        #1;
        check_value("apb write pready", 32'h1, 32'(pready));
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input hl_ctrl_pkg::apb_addr_t addr,
                            output hl_ctrl_pkg::apb_data_t data);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clock);
        penable = 1'b1;
        #1;
        data = prdata;  // Access cycle.
        check_value("apb read pready", 32'h1, 32'(pready));
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_status(input logic [2:0] mask, input logic [2:0] value,
                               input string name);
        hl_ctrl_pkg::apb_data_t status;
        int polls;
        polls = 0;
        apb_read(hl_ctrl_pkg::REG_STATUS, status);
        while (((status[2:0] & mask) != value) && polls < POLL_LIMIT) begin
            polls++;
            apb_read(hl_ctrl_pkg::REG_STATUS, status);
        end
        checks++;
        assert ((status[2:0] & mask) == value)
        else begin
            $display("%s: status never reached %b under mask %b, last read %h",
                     name, value, mask, status);
            errors++;
        end
    endtask

    // Random frame, pushed with occasional gaps so the FIFO runs empty.
    task automatic load_frame(input string name);
        for (int i = 0; i < NPIX; i++) begin
            frame_in[i] = 24'($random(seed));
            in_q.push_back(frame_in[i]);
            if (($random(seed) & 7) == 0)
                @(negedge clock);
        end
        wait_status(3'b111, 3'b001, name);
    endtask

    function automatic int quarter_table(input int i);
        case (i)
            0: return 0;
            1: return 2120;
            2: return 4096;
            3: return 5793;
            4: return 7094;
            5: return 7913;
            default: return 8192;
        endcase
    endfunction

    // Reference line: input frame with every in-bounds point recoloured.
    task automatic build_golden(input int k, input int r);
        int s;
        int c;
        int x0;
        int y0;
        int x;
        int y;
        s = (k <= 6) ? quarter_table(k) : quarter_table(12 - k);
        c = (k <= 6) ? quarter_table(6 - k) : -quarter_table(k - 6);
        x0 = (c * r) >>> hl_ctrl_pkg::FRAC_BITS;
        y0 = (s * r) >>> hl_ctrl_pkg::FRAC_BITS;
        for (int i = 0; i < NPIX; i++)
            golden[i] = frame_in[i];
        for (int t = 0; t < LINE_LENGTH; t++) begin
            x = x0 + ((t * (-s)) >>> hl_ctrl_pkg::FRAC_BITS);
            y = y0 + ((t * c) >>> hl_ctrl_pkg::FRAC_BITS);
            if (x >= 0 && x < WIDTH && y >= 0 && y < HEIGHT)
                golden[y * WIDTH + x] = hl_video_pkg::HIGHLIGHT_COLOR;
        end
    endtask

    task automatic collect_frame(input string name);
        int cycles;
        cycles = 0;
        while (out_q.size() < NPIX && cycles < FRAME_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        checks++;
        assert (out_q.size() >= NPIX)
        else begin
            $display("%s: only %0d of %0d output pixels arrived within %0d cycles",
                     name, out_q.size(), NPIX, FRAME_TIMEOUT);
            errors++;
        end
    endtask

    task automatic draw_and_compare(input string name, input int k, input int r);
        hl_ctrl_pkg::apb_data_t status;
        build_golden(k, r);
        out_q.delete();
        apb_write(hl_ctrl_pkg::REG_ANGLE, 32'(k));
        apb_write(hl_ctrl_pkg::REG_RADIUS, 32'(r));
        apb_write(hl_ctrl_pkg::REG_CTRL, 32'h1);
        collect_frame(name);
        wait_status(3'b111, 3'b100, name);
        apb_read(hl_ctrl_pkg::REG_STATUS, status);
        check_value({name, " status"}, 32'h4, status);
        check_value({name, " pixel count"}, 32'(NPIX), 32'(out_q.size()));
        for (int i = 0; i < NPIX && i < out_q.size(); i++)
            check_value($sformatf("%s pixel %0d", name, i), 32'(golden[i]), 32'(out_q[i]));
    endtask

    task automatic check_registers();
        hl_ctrl_pkg::apb_data_t data;
        apb_read(hl_ctrl_pkg::REG_STATUS, data);
        check_value("registers status after reset", 32'h0, data);
        apb_write(hl_ctrl_pkg::REG_ANGLE, 32'd5);
        apb_read(hl_ctrl_pkg::REG_ANGLE, data);
        check_value("registers angle", 32'd5, data);
        apb_write(hl_ctrl_pkg::REG_RADIUS, 32'd37);
        apb_read(hl_ctrl_pkg::REG_RADIUS, data);
        check_value("registers radius", 32'd37, data);
        apb_write(hl_ctrl_pkg::REG_ANGLE, 32'd14);
        apb_read(hl_ctrl_pkg::REG_ANGLE, data);
        check_value("registers angle clamp", 32'd11, data);  // 14 saturates at 11.
    endtask

    task automatic ignore_early_start();
        hl_ctrl_pkg::apb_data_t data;
        apb_write(hl_ctrl_pkg::REG_CTRL, 32'h1);
        apb_read(hl_ctrl_pkg::REG_STATUS, data);
        check_value("early start status", 32'h0, data);
        load_frame("early start load");
        apb_read(hl_ctrl_pkg::REG_STATUS, data);
        check_value("early start loaded", 32'h1, data);
        check_value("early start output pixels", 32'h0, 32'(out_q.size()));  // No draw ran.
    endtask

    task automatic draw_vertical_line();
        draw_and_compare("vertical line", 0, 5);  // Column x=5, all rows.
    endtask

    task automatic draw_diagonal_under_backpressure();
        load_frame("diagonal load");
        full_random = 1'b1;
        draw_and_compare("diagonal line", 3, 6);
        full_random = 1'b0;
    endtask

    task automatic clip_on_second_frame();
        load_frame("clip load");
        draw_and_compare("clipped line", 8, 10);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        full_random = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        check_registers();
        ignore_early_start();
        draw_vertical_line();
        draw_diagonal_under_backpressure();
        clip_on_second_frame();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end
endmodule

// ==== project.f ====
hdl/hl_video_pkg.sv
hdl/hl_ctrl_pkg.sv
hdl/frame_mem_if.sv
hdl/hl_apb_regs.sv
hdl/frame_loader.sv
hdl/line_drawer.sv
hdl/frame_reader.sv
hdl/frame_store.sv
hdl/highlight_top.sv
verification/highlight_tb.sv

// ==== Makefile ====
SOURCES := project.f $(wildcard hdl/*.sv) $(wildcard verification/*.sv)

.PHONY: run clean

run: obj_dir/Vhighlight_tb
	@out="$$(./obj_dir/Vhighlight_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

obj_dir/Vhighlight_tb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module highlight_tb

clean:
	rm -rf obj_dir
